//--- verification/gb_sys_stim.txt
# columns: cmd addr data exp (hex). w write, r read/compare, h held write data->exp,
# g lcg wram write after svbk=data, m wram read vs model after svbk=data,
# s irq sources, j joypad, a ack pulse, p stop pulse, c check vector=data, exp={p54,speed}
c 0000 00 00
r FF70 00 F9
r FF0F 00 E0
g C000 01 00
g D000 01 00
g D000 00 00
g D000 02 00
g D000 03 00
g D000 04 00
g D000 05 00
g D000 06 00
g D000 07 00
r FF70 00 FF
m E000 07 00
m C000 03 00
m D000 00 00
m D000 01 00
m D000 02 00
m D000 03 00
m D000 04 00
m D000 05 00
m D000 06 00
m D000 07 00
m F000 04 00
w FF70 00 00
r FF70 00 F9
w FF80 12 00
w FFFE 34 00
w FFFF 15 00
r FF80 00 12
r FFFE 00 34
r FFFF 00 15
r FF03 00 FF
s 0000 02 00
c 0000 00 00
r FF0F 00 E2
s 0000 06 00
c 0000 50 00
j 0000 0E 00
c 0000 50 00
s 0000 07 00
c 0000 40 00
r FF0F 00 F7
a 0000 00 00
r FF0F 00 F6
c 0000 50 00
a 0000 00 00
r FF0F 00 F2
c 0000 60 00
a 0000 00 00
r FF0F 00 E2
c 0000 00 00
w FF0F 00 00
r FF0F 00 E0
w FF00 20 00
r FF00 00 EE
c 0000 00 20
w FF4D 01 00
r FF4D 00 7F
p 0000 00 00
c 0000 00 21
r FF4D 00 FE
p 0000 00 00
c 0000 00 21
r FF4D 00 FE
w FF72 A5 00
w FF74 C3 00
w FF75 5A 00
h FF73 11 22
r FF72 00 A5
r FF73 00 11
r FF74 00 C3
r FF75 00 DF

//--- files.f
rtl/gb_sys_pkg.sv
rtl/gb_irq_ctrl.sv
rtl/gb_internal_ram.sv
rtl/gb_sys_regs.sv
rtl/gb_bus_ctrl.sv
rtl/gb_sys_top.sv
verification/gb_sys_tb.sv

//--- Makefile
# Verilator build for the system glue testbench

VERILATOR ?= verilator
TOP       ?= gb_sys_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timescale 1ns/1ps --assert --timing -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/gb_sys_tb.sv
//----------------------------------------------------------------------
// self-checking testbench for the system glue
// stimulus record reader, cpu bus write/read tasks, work ram model
// with lcg data, irq/speed/select checks, watchdog
//----------------------------------------------------------------------
`timescale 1ns/1ps

module gb_sys_tb;

	localparam string STIM_FILE = "verification/gb_sys_stim.txt";
	localparam int    MAX_REC   = 256;

	logic        clk_sys = 1'b0;
	logic        reset_ss;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata, cpu_rdata;
	logic        cpu_wr, cpu_rd;
	logic [3:0]  irq_src, joy_din;
	logic        irq_ack, cpu_stop;
	logic        irq, speed;
	logic [7:0]  irq_vec;
	logic [1:0]  joy_p54;

	// records as read from the file
	logic [7:0]  rec_cmd  [MAX_REC];
	logic [15:0] rec_addr [MAX_REC];
	logic [7:0]  rec_data [MAX_REC];
	logic [7:0]  rec_exp  [MAX_REC];
	int          n_rec;
	bit          loaded;

	logic [7:0]  wram_model [32768];   // physical 8 x 4k
	logic [2:0]  bank;                 // svbk as last written
	logic [31:0] lcg_state;
	int          checks, errors;

	gb_sys_top UUT (
		.clk_sys(clk_sys), .reset_ss(reset_ss),
		.cpu_addr_i(cpu_addr), .cpu_wdata_i(cpu_wdata),
		.cpu_wr_i(cpu_wr), .cpu_rd_i(cpu_rd), .cpu_rdata_o(cpu_rdata),
		.irq_src_i(irq_src), .joy_din_i(joy_din),
		.irq_ack_i(irq_ack), .cpu_stop_i(cpu_stop),
		.irq_o(irq), .irq_vec_o(irq_vec), .speed_o(speed), .joy_p54_o(joy_p54)
	);

	always #10 clk_sys = ~clk_sys;     // 20 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// memory map model of the work ram
	function automatic logic [14:0] wram_phys(input logic [15:0] a, input logic [2:0] b);
		logic [15:0] m;
		m = (a >= 16'hE000) ? a - 16'h2000 : a;   // echo mirrors C000..DDFF
		if (m < 16'hD000) return {3'd0, m[11:0]};  // fixed bank 0
		return {b, m[11:0]};
	endfunction

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cpu_addr  <= a;
		cpu_wdata <= d;
		cpu_wr    <= 1'b1;
		@(posedge clk_sys);
		cpu_wr <= 1'b0;                // strobe acted on this edge
		if (a == 16'hFF70) bank = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];
	endtask

	// strobe held over a data change so only the first value lands
	task automatic bus_write_held(input logic [15:0] a, input logic [7:0] d0, input logic [7:0] d1);
		@(posedge clk_sys);
		cpu_addr  <= a;
		cpu_wdata <= d0;
		cpu_wr    <= 1'b1;
		@(posedge clk_sys);
		cpu_wdata <= d1;
		repeat (2) @(posedge clk_sys);
		cpu_wr <= 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
		@(posedge clk_sys);
		cpu_addr <= a;
		cpu_rd   <= 1'b1;
		@(posedge clk_sys);
		cpu_rd <= 1'b0;
		repeat (2) @(posedge clk_sys); // byte lands one edge after sampling
		d = cpu_rdata;
	endtask

	task automatic check_byte(input logic [15:0] a, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR @%0t: read %h returned %h, expected %h", $time, a, got, exp);
		end
	endtask

	task automatic settle();
		repeat (4) @(posedge clk_sys);  // covers sync and edge stages
	endtask

	// ------------------------------------------------------------------
	// watchdog scaled to the record count
	initial begin
		wait (loaded);
		#(n_rec * 20 * 20 + 2000);
		$display("watchdog timeout: the stimulus did not finish in time");
		$display("Checks failed");
		$finish;
	end

	initial begin
		int          fd, code, ch;
		logic [7:0]  c, d, e, rd;
		logic [15:0] a;

		reset_ss  = 1'b1;
		cpu_addr  = 16'h0000;
		cpu_wdata = 8'h00;
		cpu_wr    = 1'b0;
		cpu_rd    = 1'b0;
		irq_src   = 4'h0;
		joy_din   = 4'hF;              // released lines high
		irq_ack   = 1'b0;
		cpu_stop  = 1'b0;
		bank      = 3'd1;
		lcg_state = 32'hea61_1483;
		checks    = 0;
		errors    = 0;
		n_rec     = 0;

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open the stimulus file %s", STIM_FILE);
		end else begin
			while (n_rec < MAX_REC && $fscanf(fd, " %c", c) == 1) begin
				if (c == "#") begin
					ch = $fgetc(fd);       // skip comment line
					while (ch != 10 && ch != -1) ch = $fgetc(fd);
				end else begin
					code = $fscanf(fd, " %h %h %h", a, d, e);
					if (code != 3) begin
						errors++;
						$display("stimulus record %0d is malformed", n_rec);
						break;
					end
					rec_cmd[n_rec]  = c;
					rec_addr[n_rec] = a;
					rec_data[n_rec] = d;
					rec_exp[n_rec]  = e;
					n_rec++;
				end
			end
			$fclose(fd);
		end
		if (n_rec == 0) begin
			errors++;
			$display("no stimulus records were read");
		end
		loaded = 1'b1;

		repeat (5) @(posedge clk_sys);
		reset_ss <= 1'b0;

		for (int i = 0; i < n_rec; i++) begin
			a = rec_addr[i];
			d = rec_data[i];
			e = rec_exp[i];
			case (rec_cmd[i])
				"w": bus_write(a, d);
				"h": bus_write_held(a, d, e);
				"r": begin
					bus_read(a, rd);
					check_byte(a, rd, e);
				end
				"g": begin                 // svbk first, then lcg byte
					bus_write(16'hFF70, d);
					lcg_state = lcg_next(lcg_state);
					bus_write(a, lcg_state[23:16]);
					wram_model[wram_phys(a, bank)] = lcg_state[23:16];
				end
				"m": begin
					bus_write(16'hFF70, d);
					bus_read(a, rd);
					check_byte(a, rd, wram_model[wram_phys(a, bank)]);
				end
				"s": begin
					@(posedge clk_sys);
					irq_src <= d[3:0];
					settle();
				end
				"j": begin
					@(posedge clk_sys);
					joy_din <= d[3:0];
					settle();
				end
				"a": begin
					@(posedge clk_sys);
					irq_ack <= 1'b1;
					@(posedge clk_sys);
					irq_ack <= 1'b0;       // clear happens at ack end
					settle();
				end
				"p": begin
					@(posedge clk_sys);
					cpu_stop <= 1'b1;
					@(posedge clk_sys);
					cpu_stop <= 1'b0;
					settle();
				end
				"c": begin                 // data = vector, exp = {p54 at 5:4, speed at 0}
					@(posedge clk_sys);
					checks++;
					if (irq !== (d != 8'h00) || irq_vec !== d) begin
						errors++;
						$display("ERROR @%0t: irq %b vector %h, expected vector %h",
							$time, irq, irq_vec, d);
					end
					checks++;
					if (speed !== e[0] || joy_p54 !== e[5:4]) begin
						errors++;
						$display("ERROR @%0t: speed %b select %b, expected %b and %b",
							$time, speed, joy_p54, e[0], e[5:4]);
					end
				end
				default: begin
					errors++;
					$display("stimulus record %0d has an unknown command", i);
				end
			endcase
		end

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- rtl/gb_sys_top.sv
//----------------------------------------------------------------------
// system glue top level
// bus controller, interrupt controller, work/high ram, system regs
//----------------------------------------------------------------------
`timescale 1ns/1ps

module gb_sys_top import gb_sys_pkg::*; (
	input  logic               clk_sys,
	input  logic               reset_ss,
	// cpu bus
	input  gb_addr_u           cpu_addr_i,
	input  logic [DATA_W-1:0]  cpu_wdata_i,
	input  logic               cpu_wr_i,
	input  logic               cpu_rd_i,
	output logic [DATA_W-1:0]  cpu_rdata_o,
	// system side
	input  logic [IRQ_N-2:0]   irq_src_i,     // vblank, lcd, timer, serial
	input  logic [JOY_W-1:0]   joy_din_i,
	input  logic               irq_ack_i,
	input  logic               cpu_stop_i,
	output logic               irq_o,
	output logic [DATA_W-1:0]  irq_vec_o,
	output logic               speed_o,
	output logic [1:0]         joy_p54_o
);

	logic [DATA_W-1:0]        wdata;
	logic                     if_wr, ie_wr, svbk_wr, key1_wr, p1_wr;
	logic                     wram_wr, wram_rd, hram_wr, hram_rd;
	logic                     spare_wr;
	logic [1:0]               spare_idx;
	logic [DATA_W-1:0]        if_val, ie_val, svbk_val, key1_val, p1_val;
	logic [3:0][DATA_W-1:0]   spare_val;    // FF72..FF75
	logic [DATA_W-1:0]        wram_rdata, hram_rdata;

	gb_bus_ctrl u_bus_ctrl (
		.clk_sys(clk_sys), .reset_ss(reset_ss),
		.cpu_addr_i(cpu_addr_i), .cpu_wdata_i(cpu_wdata_i),
		.cpu_wr_i(cpu_wr_i), .cpu_rd_i(cpu_rd_i),
		.if_val_i(if_val), .ie_val_i(ie_val), .svbk_val_i(svbk_val),
		.key1_val_i(key1_val), .p1_val_i(p1_val), .spare_val_i(spare_val),
		.wram_rdata_i(wram_rdata), .hram_rdata_i(hram_rdata),
		.cpu_rdata_o(cpu_rdata_o), .wdata_o(wdata),
		.if_wr_o(if_wr), .ie_wr_o(ie_wr), .svbk_wr_o(svbk_wr),
		.wram_wr_o(wram_wr), .wram_rd_o(wram_rd),
		.hram_wr_o(hram_wr), .hram_rd_o(hram_rd),
		.key1_wr_o(key1_wr), .p1_wr_o(p1_wr),
		.spare_wr_o(spare_wr), .spare_idx_o(spare_idx)
	);

	gb_irq_ctrl u_irq_ctrl (
		.clk_sys(clk_sys), .reset_ss(reset_ss),
		.irq_src_i(irq_src_i), .joy_din_i(joy_din_i), .irq_ack_i(irq_ack_i),
		.if_wr_i(if_wr), .ie_wr_i(ie_wr), .wdata_i(wdata),
		.if_val_o(if_val), .ie_val_o(ie_val),
		.irq_o(irq_o), .irq_vec_o(irq_vec_o)
	);

	gb_internal_ram u_internal_ram (
		.clk_sys(clk_sys), .reset_ss(reset_ss),
		.cpu_addr_i(cpu_addr_i), .wdata_i(wdata),
		.wram_wr_i(wram_wr), .wram_rd_i(wram_rd),
		.hram_wr_i(hram_wr), .hram_rd_i(hram_rd), .svbk_wr_i(svbk_wr),
		.wram_rdata_o(wram_rdata), .hram_rdata_o(hram_rdata),
		.svbk_val_o(svbk_val)
	);

	gb_sys_regs u_sys_regs (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .wdata_i(wdata),
		.key1_wr_i(key1_wr), .p1_wr_i(p1_wr),
		.spare_wr_i(spare_wr), .spare_idx_i(spare_idx),
		.cpu_stop_i(cpu_stop_i), .joy_din_i(joy_din_i),
		.key1_val_o(key1_val), .p1_val_o(p1_val), .spare_val_o(spare_val),
		.speed_o(speed_o), .joy_p54_o(joy_p54_o)
	);

endmodule

//--- rtl/gb_bus_ctrl.sv
//----------------------------------------------------------------------
// cpu bus controller
// address decode, write edge detect, per-target write strobes,
// registered read mux aligned with the synchronous ram outputs
//----------------------------------------------------------------------
`timescale 1ns/1ps

module gb_bus_ctrl import gb_sys_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset_ss,
	input  gb_addr_u               cpu_addr_i,
	input  logic [DATA_W-1:0]      cpu_wdata_i,
	input  logic                   cpu_wr_i,
	input  logic                   cpu_rd_i,
	input  logic [DATA_W-1:0]      if_val_i,
	input  logic [DATA_W-1:0]      ie_val_i,
	input  logic [DATA_W-1:0]      svbk_val_i,
	input  logic [DATA_W-1:0]      key1_val_i,
	input  logic [DATA_W-1:0]      p1_val_i,
	input  logic [3:0][DATA_W-1:0] spare_val_i,
	input  logic [DATA_W-1:0]      wram_rdata_i,
	input  logic [DATA_W-1:0]      hram_rdata_i,
	output logic [DATA_W-1:0]      cpu_rdata_o,
	output logic [DATA_W-1:0]      wdata_o,
	output logic                   if_wr_o, ie_wr_o, svbk_wr_o,
	output logic                   wram_wr_o, wram_rd_o,
	output logic                   hram_wr_o, hram_rd_o,
	output logic                   key1_wr_o, p1_wr_o,
	output logic                   spare_wr_o,
	output logic [1:0]             spare_idx_o
);

	logic [DATA_W-1:0] page, rsel;
	logic [3:0]        src_sel, src_q;     // selected read source, then its registered copy
	logic [1:0]        sidx_q;
	logic              wr_q, rd_q, wr_edge;
	logic [DATA_W-1:0] rd_mux;

	assign page    = cpu_addr_i.io[1];
	assign rsel    = cpu_addr_i.io[0];
	assign wr_edge = cpu_wr_i & ~wr_q;         // held strobe acts once
	assign wdata_o = cpu_wdata_i;
	assign spare_idx_o = rsel[1:0] - 2'd2;     // FF72 -> 0 ... FF75 -> 3

	// ------------------------------------------------------------------
	// address decode
	always_comb begin
		src_sel = SRC_NONE;
		if (page >= WRAM_FIRST_PAGE && page <= WRAM_LAST_PAGE) src_sel = SRC_WRAM;  // incl. echo
		else if (cpu_addr_i == REG_IE)   src_sel = SRC_IE;
		else if (page == IO_PAGE && rsel[7]) src_sel = SRC_HRAM;  // FF80..FFFE
		else if (cpu_addr_i == REG_IF)   src_sel = SRC_IF;
		else if (cpu_addr_i == REG_P1)   src_sel = SRC_P1;
		else if (cpu_addr_i == REG_KEY1) src_sel = SRC_KEY1;
		else if (cpu_addr_i == REG_SVBK) src_sel = SRC_SVBK;
		else if (cpu_addr_i >= REG_SPARE0 && cpu_addr_i <= REG_SPARE3) src_sel = SRC_SPARE;
	end

	// one strobe per target
	assign if_wr_o    = wr_edge && src_sel == SRC_IF;
	assign ie_wr_o    = wr_edge && src_sel == SRC_IE;
	assign svbk_wr_o  = wr_edge && src_sel == SRC_SVBK;
	assign key1_wr_o  = wr_edge && src_sel == SRC_KEY1;
	assign p1_wr_o    = wr_edge && src_sel == SRC_P1;
	assign spare_wr_o = wr_edge && src_sel == SRC_SPARE;
	assign wram_wr_o  = wr_edge && src_sel == SRC_WRAM;
	assign hram_wr_o  = wr_edge && src_sel == SRC_HRAM;
	assign wram_rd_o  = cpu_rd_i && src_sel == SRC_WRAM;
	assign hram_rd_o  = cpu_rd_i && src_sel == SRC_HRAM;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			wr_q   <= 1'b0;
			rd_q   <= 1'b0;
			src_q  <= SRC_NONE;
			sidx_q <= 2'd0;
		end else begin
			wr_q <= cpu_wr_i;
			rd_q <= cpu_rd_i;
			if (cpu_rd_i) begin          // ram output lands on this same edge
				src_q  <= src_sel;
				sidx_q <= spare_idx_o;
			end
		end
	end

	// ------------------------------------------------------------------
	// read mux, second stage
	always_comb begin
		case (src_q)
			SRC_IF:    rd_mux = if_val_i;
			SRC_IE:    rd_mux = ie_val_i;
			SRC_SVBK:  rd_mux = svbk_val_i;
			SRC_KEY1:  rd_mux = key1_val_i;
			SRC_P1:    rd_mux = p1_val_i;
			SRC_SPARE: rd_mux = spare_val_i[sidx_q];
			SRC_WRAM:  rd_mux = wram_rdata_i;
			SRC_HRAM:  rd_mux = hram_rdata_i;
			default:   rd_mux = OPEN_BUS;    // unmapped
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rd_q) cpu_rdata_o <= rd_mux;     // held until next read
	end

	a_one_write: assert property (@(posedge clk_sys) disable iff (reset_ss)
		$onehot0({if_wr_o, ie_wr_o, svbk_wr_o, key1_wr_o, p1_wr_o, spare_wr_o,
			wram_wr_o, hram_wr_o}));

endmodule

//--- rtl/gb_sys_regs.sv
//----------------------------------------------------------------------
// system registers
// KEY1 speed switch, P1 joypad select, spare cgb regs FF72..FF75
//----------------------------------------------------------------------
`timescale 1ns/1ps

module gb_sys_regs import gb_sys_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset_ss,
	input  logic [DATA_W-1:0]      wdata_i,
	input  logic                   key1_wr_i,
	input  logic                   p1_wr_i,
	input  logic                   spare_wr_i,
	input  logic [1:0]             spare_idx_i,
	input  logic                   cpu_stop_i,
	input  logic [JOY_W-1:0]       joy_din_i,
	output logic [DATA_W-1:0]      key1_val_o,
	output logic [DATA_W-1:0]      p1_val_o,
	output logic [3:0][DATA_W-1:0] spare_val_o,
	output logic                   speed_o,
	output logic [1:0]             joy_p54_o
);

	logic                   speed_q;     // 0 normal, 1 double speed
	logic                   prep_q;      // switch armed
	logic [1:0]             p54_q;
	logic [2:0][DATA_W-1:0] spare_q;     // FF72..FF74, full bytes
	logic [2:0]             ff75_q;      // bits 6..4 only

	assign key1_val_o = {speed_q, 6'h3F, prep_q};
	assign p1_val_o   = {2'b11, p54_q, joy_din_i};
	assign speed_o    = speed_q;
	assign joy_p54_o  = p54_q;

	assign spare_val_o[0] = spare_q[0];
	assign spare_val_o[1] = spare_q[1];
	assign spare_val_o[2] = spare_q[2];
	assign spare_val_o[3] = {1'b1, ff75_q, 4'hF};

	// ------------------------------------------------------------------
	// speed switch
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			speed_q <= 1'b0;
			prep_q  <= 1'b0;
		end else begin
			if (key1_wr_i) prep_q <= wdata_i[0];
			if (prep_q && cpu_stop_i) begin   // STOP performs the switch
				speed_q <= ~speed_q;
				prep_q  <= 1'b0;
			end
		end
	end

	// joypad select and spare regs
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			p54_q   <= 2'b00;
			spare_q <= '0;
			ff75_q  <= 3'd0;
		end else begin
			if (p1_wr_i) p54_q <= wdata_i[5:4];
			if (spare_wr_i) begin
				if (spare_idx_i == 2'd3) ff75_q <= wdata_i[6:4];
				else spare_q[spare_idx_i] <= wdata_i;
			end
		end
	end

endmodule

//--- rtl/gb_internal_ram.sv
//----------------------------------------------------------------------
// internal ram
// 32k banked work ram with SVBK, 127 byte high ram
//----------------------------------------------------------------------
`timescale 1ns/1ps

module gb_internal_ram import gb_sys_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset_ss,
	input  gb_addr_u          cpu_addr_i,
	input  logic [DATA_W-1:0] wdata_i,
	input  logic              wram_wr_i,
	input  logic              wram_rd_i,
	input  logic              hram_wr_i,
	input  logic              hram_rd_i,
	input  logic              svbk_wr_i,
	output logic [DATA_W-1:0] wram_rdata_o,
	output logic [DATA_W-1:0] hram_rdata_o,
	output logic [DATA_W-1:0] svbk_val_o
);

	logic [DATA_W-1:0] wram_mem [2**WRAM_ADDR_W];
	logic [DATA_W-1:0] hram_mem [2**HRAM_ADDR_W];  // top entry never selected
	logic [2:0]        svbk_q;
	logic [11:0]       offset;
	logic [WRAM_ADDR_W-1:0] wram_addr;
	logic [HRAM_ADDR_W-1:0] hram_addr;

	assign offset    = cpu_addr_i.wram[2:0];
	// a12 low -> bank 0, high -> svbk bank; echo area follows for free
	assign wram_addr = {cpu_addr_i.wram[3][0] ? svbk_q : 3'd0, offset};
	assign hram_addr = offset[HRAM_ADDR_W-1:0];
	assign svbk_val_o = {{(DATA_W-3){1'b1}}, svbk_q};

	// bank register, 0 is stored as 1
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			svbk_q <= 3'd1;
		end else if (svbk_wr_i) begin
			svbk_q <= (wdata_i[2:0] == 3'd0) ? 3'd1 : wdata_i[2:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wram_wr_i) wram_mem[wram_addr] <= wdata_i;
		if (wram_rd_i) wram_rdata_o <= wram_mem[wram_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (hram_wr_i) hram_mem[hram_addr] <= wdata_i;
		if (hram_rd_i) hram_rdata_o <= hram_mem[hram_addr];
	end

	a_svbk_nz: assert property (@(posedge clk_sys) disable iff (reset_ss)
		svbk_q != 3'd0);

endmodule

//--- rtl/gb_irq_ctrl.sv
//----------------------------------------------------------------------
// interrupt controller
// IF/IE registers, rising edge capture on four sources, joypad
// falling edge capture, fixed priority vector, clear on ack end
//----------------------------------------------------------------------
`timescale 1ns/1ps

module gb_irq_ctrl import gb_sys_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset_ss,
	input  logic [IRQ_N-2:0]  irq_src_i,
	input  logic [JOY_W-1:0]  joy_din_i,
	input  logic              irq_ack_i,
	input  logic              if_wr_i,
	input  logic              ie_wr_i,
	input  logic [DATA_W-1:0] wdata_i,
	output logic [DATA_W-1:0] if_val_o,
	output logic [DATA_W-1:0] ie_val_o,
	output logic              irq_o,
	output logic [DATA_W-1:0] irq_vec_o
);

	logic [IRQ_N-1:0]  if_q;
	logic [DATA_W-1:0] ie_q;            // full byte, upper bits plain storage
	logic [IRQ_N-2:0]  src_s, src_q;    // sampled level, previous level
	logic [JOY_W-1:0]  joy_s1, joy_s2;  // two stage sync
	logic              ack_q;
	logic [IRQ_N-1:0]  pend, pend_low, set_req;
	logic              ack_end;

	assign pend     = if_q & ie_q[IRQ_N-1:0];
	assign pend_low = pend & (~pend + IRQ_N'(1));     // lowest pending bit only
	assign ack_end  = ack_q & ~irq_ack_i;
	assign set_req  = {|(~joy_s1 & joy_s2), src_s & ~src_q};

	assign irq_o    = |pend;
	assign if_val_o = {{(DATA_W-IRQ_N){1'b1}}, if_q};  // unused bits read high
	assign ie_val_o = ie_q;

	// priority vector, lowest index wins
	always_comb begin
		irq_vec_o = '0;
		for (int i = IRQ_N-1; i >= 0; i--) begin
			if (pend[i]) irq_vec_o = IRQ_VEC_BASE + DATA_W'(IRQ_VEC_STEP * i);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_q   <= '0;
			ie_q   <= '0;
			src_s  <= '0;
			src_q  <= '0;
			joy_s1 <= '0;
			joy_s2 <= '0;
			ack_q  <= 1'b0;
		end else begin
			src_s  <= irq_src_i;
			src_q  <= src_s;
			joy_s1 <= joy_din_i;
			joy_s2 <= joy_s1;
			ack_q  <= irq_ack_i;

			// capture, and drop the serviced request at ack end
			if_q <= (if_q | set_req) & ~(ack_end ? pend_low : '0);

			// cpu write wins over captures
			if (if_wr_i) if_q <= wdata_i[IRQ_N-1:0];
			if (ie_wr_i) ie_q <= wdata_i;
		end
	end

	a_vec_irq: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(irq_vec_o != '0) == irq_o);

endmodule

//--- rtl/gb_sys_pkg.sv
//----------------------------------------------------------------------
// shared definitions for the console system glue
// bus and ram widths, io register addresses, irq vector constants,
// read-mux source codes and the cpu address union
//----------------------------------------------------------------------
package gb_sys_pkg;

	// widths
	localparam int ADDR_W      = 16;
	localparam int DATA_W      = 8;
	localparam int WRAM_ADDR_W = 15;           // 8 banks x 4k
	localparam int HRAM_ADDR_W = 7;
	localparam int IRQ_N       = 5;            // vblank, lcd, timer, serial, joypad
	localparam int JOY_W       = 4;

	// io register map
	localparam logic [ADDR_W-1:0] REG_P1     = 16'hFF00;
	localparam logic [ADDR_W-1:0] REG_IF     = 16'hFF0F;
	localparam logic [ADDR_W-1:0] REG_KEY1   = 16'hFF4D;
	localparam logic [ADDR_W-1:0] REG_SVBK   = 16'hFF70;
	localparam logic [ADDR_W-1:0] REG_SPARE0 = 16'hFF72;
	localparam logic [ADDR_W-1:0] REG_SPARE3 = 16'hFF75;
	localparam logic [ADDR_W-1:0] REG_IE     = 16'hFFFF;

	// memory pages
	localparam logic [DATA_W-1:0] WRAM_FIRST_PAGE = 8'hC0;
	localparam logic [DATA_W-1:0] WRAM_LAST_PAGE  = 8'hFD;   // echo stops at FDFF
	localparam logic [DATA_W-1:0] IO_PAGE         = 8'hFF;

	// interrupt vectors
	localparam logic [DATA_W-1:0] IRQ_VEC_BASE = 8'h40;
	localparam int                IRQ_VEC_STEP = 8;
	localparam logic [DATA_W-1:0] OPEN_BUS     = 8'hFF;

	// read mux sources
	localparam logic [3:0] SRC_NONE  = 4'd0;
	localparam logic [3:0] SRC_IF    = 4'd1;
	localparam logic [3:0] SRC_IE    = 4'd2;
	localparam logic [3:0] SRC_SVBK  = 4'd3;
	localparam logic [3:0] SRC_KEY1  = 4'd4;
	localparam logic [3:0] SRC_P1    = 4'd5;
	localparam logic [3:0] SRC_SPARE = 4'd6;
	localparam logic [3:0] SRC_WRAM  = 4'd7;
	localparam logic [3:0] SRC_HRAM  = 4'd8;

	// cpu address, two decodings of the same word
	// io:   [1] page byte, [0] register byte
	// wram: [3][3:1] region, [3][0] bank select (a12), [2:0] offset
	typedef union packed {
		logic [ADDR_W/DATA_W-1:0][DATA_W-1:0] io;
		logic [3:0][3:0]                      wram;
	} gb_addr_u;

endpackage
